// ==== flist.f ====
+incdir+.
pb_pkg.sv
pb_regs.sv
pb_ctrl.sv
pb_mem_arb.sv
pb_packet_read.sv
pb_top.sv
tb_pb_top.sv

// ==== pb_ctrl.sv ====
`timescale 1ns/1ps

module pb_ctrl (
    input  logic                 clk,
    input  logic                 srst,
    input  logic                 enable,
    input  pb_pkg::pb_cfg_t      cfg,
    input  logic                 cmd_wr,
    input  pb_pkg::cmd_code_e    cmd_code,
    input  logic                 status_rd,
    output pb_pkg::descr_t       descr,
    output logic                 descr_valid,
    input  logic                 descr_rdy,
    output pb_pkg::status_code_e status_code,
    output logic                 done,
    output logic                 en
);

    typedef enum logic [2:0] {
        RESET, DISABLED, READY, SEND_ONE, SEND_BURST, SEND_CONTINUOUS, STOP, DONE
    } state_e;

    state_e     state;
    state_e     nxt_state;
    logic       cmd_accept;
    logic [7:0] burst_size_m1;
    logic [7:0] burst_cnt;

    always_ff @(posedge clk) begin
        if (srst) state <= RESET;
        else      state <= nxt_state;
    end

    // ------------------------------------------------------------------
    // Playback FSM
    // ------------------------------------------------------------------
    always_comb begin
        nxt_state  = state;
        cmd_accept = 1'b0;
        case (state)
            RESET:    nxt_state = DISABLED;
            DISABLED: if (enable) nxt_state = READY;
            READY: begin
                if (!enable) nxt_state = DISABLED;
                else if (cmd_wr) begin
                    cmd_accept = 1'b1;
                    case (cmd_code)
                        pb_pkg::CMD_SEND_ONE:        nxt_state = SEND_ONE;
                        pb_pkg::CMD_SEND_BURST:      nxt_state = SEND_BURST;
                        pb_pkg::CMD_SEND_CONTINUOUS: nxt_state = SEND_CONTINUOUS;
                        default:                     nxt_state = DONE;
                    endcase
                end
            end
            SEND_ONE:   if (descr_rdy) nxt_state = STOP;
            SEND_BURST: if (descr_rdy && (burst_cnt == burst_size_m1)) nxt_state = STOP;
            // NOP acts as STOP here, the packet in flight still completes
            SEND_CONTINUOUS: if (cmd_wr && (cmd_code == pb_pkg::CMD_NOP)) nxt_state = STOP;
            STOP:    nxt_state = DONE;
            DONE:    nxt_state = READY;
            default: nxt_state = RESET;
        endcase
    end

    // Packet context, held for the whole command
    always_ff @(posedge clk) begin
        if (cmd_accept) begin
            descr.size    <= cfg.packet_bytes;
            descr.meta    <= cfg.meta;
            burst_size_m1 <= (cfg.burst_size == 8'd0) ? 8'd0 : cfg.burst_size - 8'd1;
        end
    end

    // Accepted descriptors in this command
    always_ff @(posedge clk) begin
        if (srst)                           burst_cnt <= '0;
        else if (cmd_accept)                burst_cnt <= '0;
        else if (descr_valid && descr_rdy)  burst_cnt <= burst_cnt + 8'd1;
    end

    assign descr_valid = state inside {SEND_ONE, SEND_BURST, SEND_CONTINUOUS};

    // Sticky done
    always_ff @(posedge clk) begin
        if (srst)                   done <= 1'b0;
        else if (state == DONE)     done <= 1'b1;
        else if (cmd_accept)        done <= 1'b0;
        else if (status_rd && done) done <= 1'b0;
    end

    always_comb begin
        case (state)
            RESET:    status_code = pb_pkg::STATUS_RESET;
            DISABLED: status_code = pb_pkg::STATUS_DISABLED;
            SEND_ONE, SEND_BURST, SEND_CONTINUOUS: status_code = pb_pkg::STATUS_BUSY;
            default:  status_code = pb_pkg::STATUS_READY;
        endcase
    end

    always_ff @(posedge clk) begin
        if (srst) en <= 1'b0;
        else      en <= enable;
    end

    // Reader only takes a descriptor that is on offer in a send state
    a_descr_rdy: assert property (@(posedge clk) disable iff (srst)
        descr_rdy |-> descr_valid);

endmodule : pb_ctrl

// ==== pb_mem_arb.sv ====
`timescale 1ns/1ps
`include "pb_params.svh"

module pb_mem_arb (
    input  logic                        clk,
    input  pb_pkg::mem_req_t            wr_req,
    input  pb_pkg::mem_req_t            rd_req,
    output logic                        rd_gnt,
    output logic [`PB_WORD_BYTES*8-1:0] rdata
);

    localparam int DATA_W = `PB_WORD_BYTES * 8;

    logic [DATA_W-1:0] mem [`PB_MEM_DEPTH];
    logic              wr_en;

    // ------------------------------------------------------------------
    // Fixed priority, the register writer always wins
    // ------------------------------------------------------------------
    assign wr_en  = wr_req.req && wr_req.wr;
    assign rd_gnt = rd_req.req && !wr_req.req;

    // Single port, one access per cycle
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_req.addr] <= wr_req.data;
        end else if (rd_gnt) begin
            rdata <= mem[rd_req.addr];
        end
    end

    // Reader side is read-only
    a_rd_no_write: assert property (@(posedge clk)
        rd_req.req |-> !rd_req.wr);

endmodule : pb_mem_arb

// ==== pb_packet_read.sv ====
`timescale 1ns/1ps
`include "pb_params.svh"

module pb_packet_read (
    input  logic                        clk,
    input  logic                        srst,
    input  pb_pkg::descr_t              descr,
    input  logic                        descr_valid,
    output logic                        descr_rdy,
    output pb_pkg::mem_req_t            rd_req,
    input  logic                        rd_gnt,
    input  logic [`PB_WORD_BYTES*8-1:0] rdata,
    output pb_pkg::pkt_t                pkt,
    output logic                        pkt_valid,
    input  logic                        pkt_rdy
);

    localparam int AW = $clog2(`PB_MEM_DEPTH);
    localparam int EW = $clog2(`PB_WORD_BYTES);

    logic          busy;
    logic          rd_active;
    logic          rd_pend;
    logic          rd_pend_last;
    logic [AW-1:0] rd_addr;
    logic [AW-1:0] last_addr;
    logic [EW-1:0] empty_last;
    logic [15:0]   meta_q;
    logic [9:0]    size_m1;
    pb_pkg::pkt_t  buf_q [2];
    logic          wr_ptr;
    logic          rd_ptr;
    logic [1:0]    count;
    logic [1:0]    occ_next;
    logic          accept;
    logic          pop;

    // A size of zero still reads one word
    assign size_m1   = (descr.size == 10'd0) ? 10'd0 : descr.size - 10'd1;
    assign accept    = descr_valid && !busy;
    assign descr_rdy = accept;

    // Held words plus the word in flight, after this cycle's pop
    assign pop      = pkt_valid && pkt_rdy;
    assign occ_next = count + {1'b0, rd_pend} - {1'b0, pop};

    assign rd_req = '{req: rd_active && (occ_next < 2'd2), wr: 1'b0, addr: rd_addr, data: '0};

    // ------------------------------------------------------------------
    // Packet and read control
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (srst) begin
            busy      <= 1'b0;
            rd_active <= 1'b0;
            rd_pend   <= 1'b0;
        end else begin
            rd_pend <= rd_gnt;
            if (accept) begin
                busy      <= 1'b1;
                rd_active <= 1'b1;
            end else begin
                if (rd_gnt && (rd_addr == last_addr)) rd_active <= 1'b0;
                if (pop && pkt.last) busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        rd_pend_last <= (rd_addr == last_addr);
        if (accept) begin
            rd_addr    <= '0;
            last_addr  <= size_m1[AW+EW-1:EW];
            empty_last <= ~descr.size[EW-1:0] + 1'b1;
            meta_q     <= descr.meta;
        end else if (rd_gnt) begin
            rd_addr <= rd_addr + 1'b1;
        end
        if (rd_pend) begin
            buf_q[wr_ptr] <= '{data: rdata, last: rd_pend_last,
                               empty: rd_pend_last ? empty_last : '0, meta: meta_q};
        end
    end

    // Two-entry output buffer
    always_ff @(posedge clk) begin
        if (srst) begin
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
            count  <= '0;
        end else begin
            if (rd_pend) wr_ptr <= ~wr_ptr;
            if (pop)     rd_ptr <= ~rd_ptr;
            count <= occ_next;
        end
    end

    assign pkt       = buf_q[rd_ptr];
    assign pkt_valid = (count != 2'd0);

    a_pkt_hold: assert property (@(posedge clk) disable iff (srst)
        pkt_valid && !pkt_rdy |=> pkt_valid && $stable(pkt));

endmodule : pb_packet_read

// ==== pb_params.svh ====
`ifndef PB_PARAMS_SVH
`define PB_PARAMS_SVH

// Packet memory geometry
`define PB_WORD_BYTES    4
`define PB_MEM_DEPTH     256

// Register map, word addresses on the strobe bus
//   control : bit 0 enable
//   config  : bits 9:0 packet bytes, bits 23:16 burst size
//   meta    : bits 15:0 packet metadata
//   command : bits 1:0 command code
//   status  : bits 1:0 status code, bit 2 done (clears on read)
`define PB_REG_CONTROL   10'd0
`define PB_REG_CONFIG    10'd1
`define PB_REG_META      10'd2
`define PB_REG_COMMAND   10'd3
`define PB_REG_STATUS    10'd4
`define PB_REG_DATA_BASE 10'd256

`endif

// ==== pb_pkg.sv ====
`include "pb_params.svh"

package pb_pkg;

    // Register strobe bus, one cycle per access
    typedef struct packed {
        logic                        wr;
        logic                        rd;
        logic [9:0]                  addr;
        logic [`PB_WORD_BYTES*8-1:0] wdata;
    } reg_req_t;

    // STOP shares the NOP code while sending continuously
    typedef enum logic [1:0] {
        CMD_NOP             = 2'd0,
        CMD_SEND_ONE        = 2'd1,
        CMD_SEND_BURST      = 2'd2,
        CMD_SEND_CONTINUOUS = 2'd3
    } cmd_code_e;

    typedef enum logic [1:0] {
        STATUS_RESET    = 2'd0,
        STATUS_DISABLED = 2'd1,
        STATUS_READY    = 2'd2,
        STATUS_BUSY     = 2'd3
    } status_code_e;

    typedef struct packed {
        logic [9:0]  packet_bytes;
        logic [7:0]  burst_size;
        logic [15:0] meta;
    } pb_cfg_t;

    typedef struct packed {
        logic [9:0]  size;
        logic [15:0] meta;
    } descr_t;

    typedef struct packed {
        logic [`PB_WORD_BYTES*8-1:0]       data;
        logic                              last;
        logic [$clog2(`PB_WORD_BYTES)-1:0] empty;
        logic [15:0]                       meta;
    } pkt_t;

    typedef struct packed {
        logic                             req;
        logic                             wr;
        logic [$clog2(`PB_MEM_DEPTH)-1:0] addr;
        logic [`PB_WORD_BYTES*8-1:0]      data;
    } mem_req_t;

endpackage : pb_pkg

// ==== pb_regs.sv ====
`timescale 1ns/1ps
`include "pb_params.svh"

module pb_regs (
    input  logic                        clk,
    input  logic                        srst,
    input  pb_pkg::reg_req_t            reg_req,
    output logic [`PB_WORD_BYTES*8-1:0] reg_rdata,
    output logic                        reg_rvalid,
    output logic                        enable,
    output pb_pkg::pb_cfg_t             cfg,
    output logic                        cmd_wr,
    output pb_pkg::cmd_code_e           cmd_code,
    output logic                        status_rd,
    input  pb_pkg::status_code_e        status_code,
    input  logic                        done,
    output pb_pkg::mem_req_t            mem_wr
);

    localparam int DATA_W = `PB_WORD_BYTES * 8;
    localparam int AW     = $clog2(`PB_MEM_DEPTH);

    logic       data_wr;
    logic [9:0] data_offs;

    // Data window decode
    assign data_wr   = reg_req.wr && (reg_req.addr >= `PB_REG_DATA_BASE);
    assign data_offs = reg_req.addr - `PB_REG_DATA_BASE;

    // Read of status lets the controller clear its sticky flags
    assign status_rd = reg_req.rd && (reg_req.addr == `PB_REG_STATUS);

    // ------------------------------------------------------------------
    // Register writes
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (srst) begin
            enable   <= 1'b0;
            cfg      <= '0;
            cmd_wr   <= 1'b0;
            cmd_code <= pb_pkg::CMD_NOP;
            mem_wr   <= '0;
        end else begin
            cmd_wr      <= 1'b0;
            mem_wr.req  <= data_wr;
            mem_wr.wr   <= data_wr;
            mem_wr.addr <= data_offs[AW-1:0];
            mem_wr.data <= reg_req.wdata;
            if (reg_req.wr) begin
                case (reg_req.addr)
                    `PB_REG_CONTROL: enable <= reg_req.wdata[0];
                    `PB_REG_CONFIG: begin
                        cfg.packet_bytes <= reg_req.wdata[9:0];
                        cfg.burst_size   <= reg_req.wdata[23:16];
                    end
                    `PB_REG_META: cfg.meta <= reg_req.wdata[15:0];
                    `PB_REG_COMMAND: begin
                        cmd_wr   <= 1'b1;
                        cmd_code <= pb_pkg::cmd_code_e'(reg_req.wdata[1:0]);
                    end
                    default: ;
                endcase
            end
        end
    end

    // ------------------------------------------------------------------
    // Readback, one cycle after the strobe
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (srst) reg_rvalid <= 1'b0;
        else      reg_rvalid <= reg_req.rd;
    end

    // Data window is write-only and reads back as zero
    always_ff @(posedge clk) begin
        if (reg_req.rd) begin
            case (reg_req.addr)
                `PB_REG_CONTROL: reg_rdata <= DATA_W'(enable);
                `PB_REG_CONFIG:  reg_rdata <= DATA_W'({cfg.burst_size, 6'b0, cfg.packet_bytes});
                `PB_REG_META:    reg_rdata <= DATA_W'(cfg.meta);
                `PB_REG_COMMAND: reg_rdata <= DATA_W'(cmd_code);
                `PB_REG_STATUS:  reg_rdata <= DATA_W'({done, status_code});
                default:         reg_rdata <= '0;
            endcase
        end
    end

    a_no_rd_wr: assert property (@(posedge clk) disable iff (srst)
        !(reg_req.wr && reg_req.rd));

endmodule : pb_regs

// ==== pb_top.sv ====
`timescale 1ns/1ps
`include "pb_params.svh"

module pb_top (
    input  logic                        clk,
    input  logic                        srst,
    input  pb_pkg::reg_req_t            reg_req,
    output logic [`PB_WORD_BYTES*8-1:0] reg_rdata,
    output logic                        reg_rvalid,
    output pb_pkg::pkt_t                pkt,
    output logic                        pkt_valid,
    input  logic                        pkt_rdy,
    output logic                        en
);

    logic                        enable;
    pb_pkg::pb_cfg_t             cfg;
    logic                        cmd_wr;
    pb_pkg::cmd_code_e           cmd_code;
    logic                        status_rd;
    pb_pkg::status_code_e        status_code;
    logic                        done;
    pb_pkg::mem_req_t            mem_wr;
    pb_pkg::descr_t              descr;
    logic                        descr_valid;
    logic                        descr_rdy;
    pb_pkg::mem_req_t            rd_req;
    logic                        rd_gnt;
    logic [`PB_WORD_BYTES*8-1:0] mem_rdata;

    pb_regs i_pb_regs (
        .clk, .srst, .reg_req, .reg_rdata, .reg_rvalid, .enable, .cfg,
        .cmd_wr, .cmd_code, .status_rd, .status_code, .done, .mem_wr
    );

    pb_ctrl i_pb_ctrl (
        .clk, .srst, .enable, .cfg, .cmd_wr, .cmd_code, .status_rd,
        .descr, .descr_valid, .descr_rdy, .status_code, .done, .en
    );

    // Register writer and packet reader share the one RAM port
    pb_mem_arb i_pb_mem_arb (
        .clk, .wr_req (mem_wr), .rd_req, .rd_gnt, .rdata (mem_rdata)
    );

    pb_packet_read i_pb_packet_read (
        .clk, .srst, .descr, .descr_valid, .descr_rdy, .rd_req, .rd_gnt,
        .rdata (mem_rdata), .pkt, .pkt_valid, .pkt_rdy
    );

endmodule : pb_top

// ==== run.sh ====
#!/bin/sh
# Build and run the playback engine testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert -Wno-fatal -f flist.f \
        --top-module tb_pb_top -o tb_pb_top; then
    echo "Verilator build failed"
    exit 1
fi

if ! ./obj_dir/tb_pb_top > "$LOG" 2>&1; then
    cat "$LOG"
    echo "Simulation exited with an error"
    exit 1
fi

cat "$LOG"

if grep -q "STATUS: FAIL" "$LOG"; then
    exit 1
fi

if ! grep -q "STATUS: PASS" "$LOG"; then
    echo "Simulation log holds no result"
    exit 1
fi

exit 0

// ==== tb_pb_top.sv ====
`timescale 1ns/1ps
`include "pb_params.svh"

module tb_pb_top;

    typedef enum logic [2:0] {
        OP_WR, OP_RD, OP_FILL, OP_CMD, OP_CONT
    } op_e;

    // addr: register or word count (fill); data: write data, fill base, command or stop delay
    // exp: read data or packet count; bytes: packet size for command rows
    typedef struct packed {
        op_e         op;
        logic [9:0]  addr;
        logic [31:0] data;
        logic [31:0] exp;
        logic [9:0]  bytes;
    } row_t;

    localparam int NUM_ROWS        = 30;
    localparam int WATCHDOG_CYCLES = NUM_ROWS * 200;

    logic              clk;
    logic              srst = 1'b1;
    pb_pkg::reg_req_t  reg_req = '0;
    logic [31:0]       reg_rdata;
    logic              reg_rvalid;
    pb_pkg::pkt_t      pkt;
    logic              pkt_valid;
    logic              pkt_rdy = 1'b0;
    logic              en;

    logic [7:0]        model_mem [0:4*`PB_MEM_DEPTH-1];
    logic [15:0]       meta_shadow = '0;
    logic [15:0]       mon_meta = '0;
    int                mon_size = 0;
    int                beat_idx = 0;
    int                pkt_count = 0;
    int                cur_row = 0;
    int                reg_errors = 0;
    int                pkt_errors = 0;
    int                flow_errors = 0;
    logic [15:0]       lfsr_state = 16'd18;

    row_t rows [NUM_ROWS] = '{
        // Reset state, enable, readback
        '{OP_RD,   `PB_REG_STATUS,  32'd0,            32'd1,            10'd0},
        '{OP_WR,   `PB_REG_CONTROL, 32'd1,            32'd0,            10'd0},
        '{OP_RD,   `PB_REG_STATUS,  32'd0,            32'd2,            10'd0},
        '{OP_RD,   `PB_REG_CONTROL, 32'd0,            32'd1,            10'd0},
        '{OP_FILL, 10'd4,           32'h0011_2233,    32'd0,            10'd0},
        '{OP_WR,   `PB_REG_META,    32'h0000_beef,    32'd0,            10'd0},
        '{OP_WR,   `PB_REG_CONFIG,  32'h0003_000a,    32'd0,            10'd0},
        '{OP_RD,   `PB_REG_CONFIG,  32'd0,            32'h0003_000a,    10'd0},
        // Single packet, then sticky done
        '{OP_CMD,  10'd0, 32'(pb_pkg::CMD_SEND_ONE),  32'd1,            10'd10},
        '{OP_RD,   `PB_REG_STATUS,  32'd0,            32'd6,            10'd0},
        '{OP_RD,   `PB_REG_STATUS,  32'd0,            32'd2,            10'd0},
        // Bursts of 3 and of 0
        '{OP_CMD,  10'd0, 32'(pb_pkg::CMD_SEND_BURST), 32'd3,           10'd10},
        '{OP_RD,   `PB_REG_STATUS,  32'd0,            32'd6,            10'd0},
        '{OP_RD,   `PB_REG_STATUS,  32'd0,            32'd2,            10'd0},
        '{OP_WR,   `PB_REG_CONFIG,  32'h0000_0007,    32'd0,            10'd0},
        '{OP_CMD,  10'd0, 32'(pb_pkg::CMD_SEND_BURST), 32'd1,           10'd7},
        '{OP_RD,   `PB_REG_STATUS,  32'd0,            32'd6,            10'd0},
        // New data window contents
        '{OP_FILL, 10'd8,           32'ha5c3_0f96,    32'd0,            10'd0},
        '{OP_WR,   `PB_REG_META,    32'h0000_1234,    32'd0,            10'd0},
        '{OP_WR,   `PB_REG_CONFIG,  32'h0002_001d,    32'd0,            10'd0},
        '{OP_CMD,  10'd0, 32'(pb_pkg::CMD_SEND_BURST), 32'd2,           10'd29},
        '{OP_CONT, 10'd0,           32'd60,           32'd0,            10'd29},
        '{OP_RD,   `PB_REG_STATUS,  32'd0,            32'd6,            10'd0},
        '{OP_RD,   `PB_REG_STATUS,  32'd0,            32'd2,            10'd0},
        // Commands while disabled are dropped
        '{OP_WR,   `PB_REG_CONTROL, 32'd0,            32'd0,            10'd0},
        '{OP_RD,   `PB_REG_STATUS,  32'd0,            32'd1,            10'd0},
        '{OP_CMD,  10'd0, 32'(pb_pkg::CMD_SEND_ONE),  32'd0,            10'd29},
        '{OP_WR,   `PB_REG_CONTROL, 32'd1,            32'd0,            10'd0},
        '{OP_CMD,  10'd0, 32'(pb_pkg::CMD_SEND_ONE),  32'd1,            10'd29},
        '{OP_RD,   `PB_REG_STATUS,  32'd0,            32'd6,            10'd0}
    };

    pb_top i_dut (
        .clk, .srst, .reg_req, .reg_rdata, .reg_rvalid, .pkt, .pkt_valid, .pkt_rdy, .en
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // 16-bit Fibonacci LFSR, taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    // Ready is high on three cycles out of four on average
    always @(posedge clk) begin : rdy_driver
        logic b0;
        logic b1;
        lfsr_state = lfsr_next(lfsr_state);
        b0         = lfsr_state[0];
        lfsr_state = lfsr_next(lfsr_state);
        b1         = lfsr_state[0];
        pkt_rdy <= b0 | b1;
    end

    // ----------------------------------------------------------------------
    // Register bus access
    // ----------------------------------------------------------------------
    task automatic reg_write(input logic [9:0] addr, input logic [31:0] data);
        int w;
        @(posedge clk);
        reg_req <= '{wr: 1'b1, rd: 1'b0, addr: addr, wdata: data};
        @(posedge clk);
        reg_req <= '0;
        // Network byte order, first byte in bits 31:24
        if (addr >= `PB_REG_DATA_BASE) begin
            w = int'(addr - `PB_REG_DATA_BASE);
            for (int j = 0; j < 4; j++) model_mem[w*4+j] = data[31-8*j -: 8];
        end
        if (addr == `PB_REG_META) meta_shadow = data[15:0];
    endtask

    task automatic reg_read(input logic [9:0] addr, output logic [31:0] data);
        @(posedge clk);
        reg_req <= '{wr: 1'b0, rd: 1'b1, addr: addr, wdata: 32'd0};
        @(posedge clk);
        reg_req <= '0;
        @(negedge clk);
        data = reg_rdata;
        if (reg_rvalid !== 1'b1) begin
            $display("ERROR: row %0d, no read response one cycle after the strobe", cur_row);
            flow_errors++;
            data = 'x;
        end
    endtask

    task automatic fill_words(input int count, input logic [31:0] base);
        for (int w = 0; w < count; w++) begin
            reg_write(10'(`PB_REG_DATA_BASE + w), base ^ (32'(w) * 32'h9e37_79b1));
        end
    endtask

    task automatic wait_idle();
        int idle;
        int waited;
        idle   = 0;
        waited = 0;
        while (idle < 16 && waited < 600) begin
            @(negedge clk);
            waited++;
            if (pkt_valid) idle = 0;
            else           idle++;
        end
        if (idle < 16) begin
            $display("ERROR: row %0d, packet output never went idle", cur_row);
            flow_errors++;
        end
    endtask

    // ----------------------------------------------------------------------
    // Commands
    // ----------------------------------------------------------------------
    task automatic run_command(input logic [1:0] code, input int exp_count, input int bytes);
        int start;
        int waited;
        mon_size = bytes;
        mon_meta = meta_shadow;
        start    = pkt_count;
        waited   = 0;
        reg_write(`PB_REG_COMMAND, 32'(code));
        while ((pkt_count - start) < exp_count && waited < 400) begin
            @(negedge clk);
            waited++;
        end
        if ((pkt_count - start) < exp_count) begin
            $display("ERROR: row %0d, timed out waiting for %0d packets", cur_row, exp_count);
            flow_errors++;
        end
        wait_idle();
        if ((pkt_count - start) != exp_count) begin
            $display("CHECK FAILED @ %0t: row %0d, packet count %0d, expected %0d",
                     $time, cur_row, pkt_count - start, exp_count);
            flow_errors++;
        end
        if (beat_idx != 0) begin
            $display("CHECK FAILED @ %0t: row %0d, packet cut short", $time, cur_row);
            flow_errors++;
        end
    endtask

    task automatic run_continuous(input int delay, input int bytes);
        int start;
        mon_size = bytes;
        mon_meta = meta_shadow;
        start    = pkt_count;
        reg_write(`PB_REG_COMMAND, 32'(pb_pkg::CMD_SEND_CONTINUOUS));
        repeat (delay) @(posedge clk);
        // NOP while sending continuously means stop
        reg_write(`PB_REG_COMMAND, 32'(pb_pkg::CMD_NOP));
        wait_idle();
        if ((pkt_count - start) < 1) begin
            $display("CHECK FAILED @ %0t: row %0d, no packet before stop", $time, cur_row);
            flow_errors++;
        end
        if (beat_idx != 0) begin
            $display("CHECK FAILED @ %0t: row %0d, last beat before idle lacks last",
                     $time, cur_row);
            flow_errors++;
        end
    endtask

    // ----------------------------------------------------------------------
    // Packet monitor against the byte model
    // ----------------------------------------------------------------------
    always @(negedge clk) begin : beat_monitor
        int          nwords;
        int          b;
        logic [31:0] exp_word;
        logic [31:0] mask;
        logic        exp_last;
        logic [1:0]  exp_empty;
        if (!srst && pkt_valid && pkt_rdy) begin
            nwords    = (mon_size + 3) / 4;
            exp_word  = '0;
            mask      = '0;
            exp_empty = 2'((4 - mon_size % 4) % 4);
            for (int j = 0; j < 4; j++) begin
                b = beat_idx * 4 + j;
                if (b < mon_size) begin
                    exp_word[31-8*j -: 8] = model_mem[b];
                    mask[31-8*j -: 8]     = 8'hff;
                end
            end
            exp_last = (beat_idx == nwords - 1);
            if ((pkt.data & mask) !== exp_word) begin
                $display("CHECK FAILED @ %0t: beat %0d data %h, expected %h",
                         $time, beat_idx, pkt.data & mask, exp_word);
                pkt_errors++;
            end
            if (pkt.last !== exp_last) begin
                $display("CHECK FAILED @ %0t: beat %0d last %b, expected %b",
                         $time, beat_idx, pkt.last, exp_last);
                pkt_errors++;
            end
            if (exp_last && pkt.empty !== exp_empty) begin
                $display("CHECK FAILED @ %0t: empty %0d, expected %0d",
                         $time, pkt.empty, exp_empty);
                pkt_errors++;
            end
            if (pkt.meta !== mon_meta) begin
                $display("CHECK FAILED @ %0t: meta %h, expected %h", $time, pkt.meta, mon_meta);
                pkt_errors++;
            end
            if (pkt.last === 1'b1) begin
                beat_idx = 0;
                pkt_count++;
            end else begin
                beat_idx++;
            end
        end
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("ERROR: watchdog expired before the stimulus table finished");
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin : main
        logic [31:0] rd;
        repeat (8) @(posedge clk);
        srst <= 1'b0;
        @(negedge clk);
        if (en !== 1'b0 || pkt_valid !== 1'b0) begin
            $display("CHECK FAILED @ %0t: en %b pkt_valid %b after reset", $time, en, pkt_valid);
            flow_errors++;
        end
        for (int i = 0; i < NUM_ROWS; i++) begin
            cur_row = i;
            case (rows[i].op)
                OP_WR: begin
                    reg_write(rows[i].addr, rows[i].data);
                    if (rows[i].addr == `PB_REG_CONTROL) begin
                        repeat (2) @(negedge clk);
                        if (en !== rows[i].data[0]) begin
                            $display("CHECK FAILED @ %0t: row %0d, en %b", $time, i, en);
                            flow_errors++;
                        end
                    end
                end
                OP_RD: begin
                    reg_read(rows[i].addr, rd);
                    if (rd !== rows[i].exp) begin
                        $display("CHECK FAILED @ %0t: row %0d, read %h, expected %h",
                                 $time, i, rd, rows[i].exp);
                        reg_errors++;
                    end
                end
                OP_FILL: fill_words(int'(rows[i].addr), rows[i].data);
                OP_CMD:  run_command(rows[i].data[1:0], int'(rows[i].exp), int'(rows[i].bytes));
                OP_CONT: run_continuous(int'(rows[i].data), int'(rows[i].bytes));
                default: ;
            endcase
            repeat (2) @(posedge clk);
        end
        $display("Errors: register %0d, packet %0d, flow %0d, packets seen %0d",
                 reg_errors, pkt_errors, flow_errors, pkt_count);
        if (reg_errors + pkt_errors + flow_errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule : tb_pb_top
